//--- Makefile
# Verilator lint and simulation of the decode stage testbench
VERILATOR ?= verilator
TOP       ?= tb_decodeStage
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
+incdir+verilog
verilog/decode_pkg.sv
verilog/decodeMulticycle.sv
verilog/decodeRegFields.sv
verilog/decodeImmediate.sv
verilog/decodeControl.sv
verilog/decodeStage.sv
tb/decodeStage_assert.sv
tb/tb_decodeStage.sv

//--- tb/decodeStage_assert.sv
// Concurrent assertions that bind attaches to the decode stage to check its decode rules and stall timing
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module decodeStage_assert (
	input logic                      clk,
	input logic                      rstN,
	input decode_pkg::instruction_t  instr,
	input logic                      instrValid,
	input decode_pkg::decodeBundle_t decoded,
	input logic                      decodedValid,
	input logic                      stall
);

	import decode_pkg::*;

	// Number of assertion failures so far
	int errorCount = 0;

	logic         accepted;
	logic         acceptedQ;
	instruction_t lastInstr;
	int unsigned  stallLeft;

	// ==================================================
	// Expected decode from the format rules
	// ==================================================

	function automatic unitClass_e classifyUnit(input instruction_t ir);
		if (ir.any.opcode == OP_R2)
		begin
			if (ir.r2.func inside {FN_ADD, FN_SUB, FN_AND, FN_OR})
				return UNIT_ALU;
			if (ir.r2.func inside {FN_MUL, FN_MULU, FN_MULSU})
				return UNIT_MUL;
			if (ir.r2.func inside {FN_DIV, FN_DIVU, FN_DIVSU, FN_MOD, FN_MODU, FN_MODSU})
				return UNIT_DIV;
			return UNIT_NOP;
		end
		if (ir.any.opcode inside {OP_ADDI, OP_ANDI, OP_ORI})
			return UNIT_ALU;
		if (ir.any.opcode inside {OP_MULI, OP_MULUI})
			return UNIT_MUL;
		if (ir.any.opcode inside {OP_DIVI, OP_DIVUI})
			return UNIT_DIV;
		if (ir.any.opcode inside {OP_LOAD, OP_STORE})
			return UNIT_MEM;
		if (ir.any.opcode == OP_BRANCH)
			return UNIT_BRANCH;
		return UNIT_NOP;
	endfunction

	// Only the multiply and divide units take more than one cycle
	function automatic logic needsStall(input instruction_t ir);
		return classifyUnit(ir) inside {UNIT_MUL, UNIT_DIV};
	endfunction

	function automatic logic [31:0] extendImm(input instruction_t ir);
		logic [31:0] ext;
		ext = {{(32 - `QD_IMM_BITS){ir.ri.imm[`QD_IMM_BITS - 1]}}, ir.ri.imm};
		if (ir.any.opcode inside {OP_ANDI, OP_ORI, OP_MULUI, OP_DIVUI})
			ext[31:`QD_IMM_BITS] = '0;
		else if (!(ir.any.opcode inside {OP_ADDI, OP_MULI, OP_DIVI, OP_LOAD, OP_STORE,
			OP_BRANCH}))
			ext = '0;
		return ext;
	endfunction

	function automatic regFields_t extractFields(input instruction_t ir);
		regFields_t f;
		logic       isImm;
		logic       hasRd;
		f = '0;
		isImm = ir.any.opcode inside {OP_ADDI, OP_ANDI, OP_ORI, OP_MULI, OP_MULUI,
			OP_DIVI, OP_DIVUI, OP_LOAD};
		hasRd = isImm || (ir.any.opcode == OP_R2);
		f.readsRs1 = hasRd || (ir.any.opcode inside {OP_STORE, OP_BRANCH});
		f.readsRs2 = ir.any.opcode inside {OP_R2, OP_STORE, OP_BRANCH};
		f.writesRd = hasRd && (ir.ri.rd != 5'd0);
		if (hasRd)
			f.rd = ir.ri.rd;
		if (f.readsRs1)
			f.rs1 = ir.ri.rs1;
		// Second source always sits where the r2 view puts it
		if (f.readsRs2)
			f.rs2 = ir.r2.rs2;
		return f;
	endfunction

	// ==================================================
	// Acceptance and stall model
	// ==================================================

	// Acceptance follows the modelled stall level and not the one the stage drives
	assign accepted = instrValid && (stallLeft == 0);

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			acceptedQ <= 1'b0;
			stallLeft <= 0;
		end
		else
		begin
			acceptedQ <= accepted;
			if (accepted && classifyUnit(instr) == UNIT_MUL)
				stallLeft <= `QD_MUL_STALL;
			else if (accepted && classifyUnit(instr) == UNIT_DIV)
				stallLeft <= `QD_DIV_STALL;
			else if (stallLeft != 0)
				stallLeft <= stallLeft - 1;
		end
		// Raw word of the item now being registered
		if (accepted)
			lastInstr <= instr;
	end

	resetLow: assert property (@(posedge clk) !rstN |=> !decodedValid && !stall)
	else
	begin
		errorCount++;
		$error("[ERROR] decodedValid,stall after reset exp=0,0 got=%h,%h",
			$sampled(decodedValid), $sampled(stall));
	end

	// Exactly one pulse follows each acceptance by one cycle and none appears otherwise
	validPulse: assert property (@(posedge clk) disable iff (!rstN) decodedValid == acceptedQ)
	else
	begin
		errorCount++;
		$error("[ERROR] decodedValid exp=%h got=%h",
			$sampled(acceptedQ), $sampled(decodedValid));
	end

	stallLength: assert property (@(posedge clk) disable iff (!rstN) stall == (stallLeft != 0))
	else
	begin
		errorCount++;
		$error("[ERROR] stall exp=%h got=%h",
			$sampled(stallLeft != 0), $sampled(stall));
	end

	multicycleFlag: assert property (@(posedge clk) disable iff (!rstN)
		decodedValid |-> decoded.multicycle == needsStall(lastInstr))
	else
	begin
		errorCount++;
		$error("[ERROR] decoded.multicycle exp=%h got=%h",
			needsStall($sampled(lastInstr)), $sampled(decoded.multicycle));
	end

	unitClass: assert property (@(posedge clk) disable iff (!rstN)
		decodedValid |-> decoded.unit == classifyUnit(lastInstr))
	else
	begin
		errorCount++;
		$error("[ERROR] decoded.unit exp=%h got=%h",
			classifyUnit($sampled(lastInstr)), $sampled(decoded.unit));
	end

	regFields: assert property (@(posedge clk) disable iff (!rstN)
		decodedValid |-> decoded.fields == extractFields(lastInstr))
	else
	begin
		errorCount++;
		$error("[ERROR] decoded.fields exp=%h got=%h",
			extractFields($sampled(lastInstr)), $sampled(decoded.fields));
	end

	// The raw opcode travels with the immediate so both are checked together
	immValue: assert property (@(posedge clk) disable iff (!rstN)
		decodedValid |-> decoded.imm == extendImm(lastInstr)
			&& decoded.opcode == lastInstr.any.opcode)
	else
	begin
		errorCount++;
		$error("[ERROR] decoded.imm exp=%h got=%h opcode=%h",
			extendImm($sampled(lastInstr)), $sampled(decoded.imm), $sampled(decoded.opcode));
	end

endmodule

bind decodeStage decodeStage_assert uAssert (.*);

`default_nettype wire

//--- tb/tb_decodeStage.sv
// Testbench for the decode stage, drives random instruction words while bound assertions check them
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module tb_decodeStage;

	import decode_pkg::*;

	localparam int clkPeriod   = 4;
	localparam int resetCycles = 8;
	localparam int attempts    = 400;
	// Worst attempt is one issue cycle plus the divide stall
	localparam int timeoutNs   = (attempts * (`QD_DIV_STALL + 2) + resetCycles) * clkPeriod;

	// Every opcode plus one unassigned code that has to decode as NOP
	localparam logic [6:0] opTable [13] = '{OP_R2, OP_ADDI, OP_ANDI, OP_ORI, OP_MULI,
		OP_MULUI, OP_DIVI, OP_DIVUI, OP_LOAD, OP_STORE, OP_BRANCH, OP_NOP, 7'h33};
	// Every function code plus one unassigned code
	localparam logic [5:0] fnTable [14] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_MUL, FN_MULU,
		FN_MULSU, FN_DIV, FN_DIVU, FN_DIVSU, FN_MOD, FN_MODU, FN_MODSU, 6'h3F};

	logic          clk;
	logic          rstN;
	instruction_t  instr;
	logic          instrValid;
	decodeBundle_t decoded;
	logic          decodedValid;
	logic          stall;

	decodeStage u_dut (
		.clk          (clk),
		.rstN         (rstN),
		.instr        (instr),
		.instrValid   (instrValid),
		.decoded      (decoded),
		.decodedValid (decodedValid),
		.stall        (stall)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Random register and immediate bits under a table opcode
	function automatic instruction_t randomWord();
		instruction_t w;
		w = $urandom();
		w.any.opcode = opcode_e'(opTable[4'($urandom_range(12, 0))]);
		if (w.any.opcode == OP_R2)
			w.r2.func = func_e'(fnTable[4'($urandom_range(13, 0))]);
		// Destination zero now and then, so the dropped write gets exercised
		if ($urandom_range(7, 0) == 0)
			w.r2.rd = 5'd0;
		return w;
	endfunction

	// ==================================================
	// Stimulus
	// ==================================================

	initial
	begin
		int errors;
		void'($urandom(4916));
		rstN       = 1'b0;
		instr      = '0;
		instrValid = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#0.5;
		rstN = 1'b1;
		for (int i = 0; i < attempts; i++)
		begin
			// Upstream keeps the word and its strobe while the stage stalls
			while (stall)
			begin
				@(posedge clk);
				#0.5;
			end
			instr      = randomWord();
			instrValid = ($urandom_range(3, 0) != 0);
			@(posedge clk);
			#0.5;
		end
		instrValid = 1'b0;
		// Let the last stall run out and the last pulse be checked
		repeat (`QD_DIV_STALL + 2) @(posedge clk);
		#0.5;
		errors = u_dut.uAssert.errorCount;
		$display("Run finished after %0d attempts with %0d assertion errors", attempts, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// Watchdog in case the stage never drops stall
	initial
	begin
		#(timeoutNs);
		$display("Timeout: the stimulus did not complete within %0d ns", timeoutNs);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/decodeControl.sv
// Accepts instructions, registers the decoded bundle, classifies the unit and times multicycle stalls
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module decodeControl (
	input  logic                      clk,
	input  logic                      rstN,
	input  decode_pkg::instruction_t  instr,
	input  logic                      instrValid,
	input  logic                      multicycle,
	input  decode_pkg::regFields_t    fields,
	input  logic [31:0]               imm,
	output decode_pkg::decodeBundle_t decoded,
	output logic                      decodedValid,
	output logic                      stall
);

	import decode_pkg::*;

	// Counter must hold the longer of the two stall lengths
	localparam int stallMax = (`QD_MUL_STALL > `QD_DIV_STALL) ? `QD_MUL_STALL : `QD_DIV_STALL;
	localparam int cntBits  = $clog2(stallMax + 1);

	logic               accept;
	unitClass_e         unit;
	logic [cntBits-1:0] stallLoad;
	logic [cntBits-1:0] stallCnt;

	// ==================================================
	// Unit classification
	// ==================================================

	function automatic unitClass_e fnUnit(input instruction_t ir);
		unitClass_e u;
		u = UNIT_NOP;
		case (ir.any.opcode)
			OP_R2:
			begin
				case (ir.r2.func)
					FN_ADD, FN_SUB, FN_AND, FN_OR:
						u = UNIT_ALU;
					FN_MUL, FN_MULU, FN_MULSU:
						u = UNIT_MUL;
					FN_DIV, FN_DIVU, FN_DIVSU, FN_MOD, FN_MODU, FN_MODSU:
						u = UNIT_DIV;
					default:
						u = UNIT_NOP;
				endcase
			end
			OP_ADDI, OP_ANDI, OP_ORI:
				u = UNIT_ALU;
			OP_MULI, OP_MULUI:
				u = UNIT_MUL;
			OP_DIVI, OP_DIVUI:
				u = UNIT_DIV;
			OP_LOAD, OP_STORE:
				u = UNIT_MEM;
			OP_BRANCH:
				u = UNIT_BRANCH;
			// NOP and anything not recognised
			default:
				u = UNIT_NOP;
		endcase
		return u;
	endfunction

	assign unit = fnUnit(instr);

	// Stall length depends on which multicycle unit is busy
	always_comb
	begin
		case (unit)
			UNIT_MUL: stallLoad = cntBits'(`QD_MUL_STALL);
			UNIT_DIV: stallLoad = cntBits'(`QD_DIV_STALL);
			default:  stallLoad = '0;
		endcase
	end

	// ==================================================
	// Acceptance and stall timing
	// ==================================================

	// Upstream holds the word while stall is up, so instrValid is ignored then
	assign accept = instrValid && !stall;
	assign stall  = (stallCnt != '0);

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			decodedValid <= 1'b0;
			stallCnt     <= '0;
		end
		else
		begin
			// One-cycle pulse in the cycle after acceptance
			decodedValid <= accept;
			if (accept && multicycle)
				stallCnt <= stallLoad;
			else if (stall)
				stallCnt <= stallCnt - 1'b1;
		end
	end

	// Bundle is only captured on acceptance and read under decodedValid
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			decoded.fields     <= fields;
			decoded.imm        <= imm;
			decoded.unit       <= unit;
			decoded.multicycle <= multicycle;
			decoded.opcode     <= instr.any.opcode;
		end
	end

endmodule

`default_nettype wire

//--- verilog/decodeImmediate.sv
// Sign- or zero-extends the register-immediate field to 32 bits according to opcode
`timescale 1ns/1ps
`default_nettype none

module decodeImmediate (
	input  decode_pkg::instruction_t instr,
	output logic [31:0]              imm
);

	import decode_pkg::*;

	logic [31:0] immZero;
	logic [31:0] immSign;

	// Both extensions of the raw field, the opcode picks one below
	assign immZero = 32'(instr.ri.imm);
	assign immSign = 32'($signed(instr.ri.imm));

	always_comb
	begin
		case (instr.any.opcode)
			// Logical and unsigned arithmetic take the field as unsigned
			OP_ANDI, OP_ORI, OP_MULUI, OP_DIVUI:
				imm = immZero;
			// Signed arithmetic and address offsets
			OP_ADDI, OP_MULI, OP_DIVI:
				imm = immSign;
			OP_LOAD, OP_STORE, OP_BRANCH:
				imm = immSign;
			// R2, NOP and unknown opcodes carry no immediate
			default:
				imm = 32'd0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/decodeMulticycle.sv
// Flags instructions that occupy the multicycle multiply and divide unit, purely combinational
`timescale 1ns/1ps
`default_nettype none

module decodeMulticycle (
	input  decode_pkg::instruction_t instr,
	output logic                     multicycle
);

	import decode_pkg::*;

	// True for every operation the iterative unit executes
	function automatic logic fnIsMulticycle(input instruction_t ir);
		logic isMc;
		isMc = 1'b0;
		case (ir.any.opcode)
			OP_R2:
			begin
				// Only the multiply, divide and modulo function codes
				case (ir.r2.func)
					FN_MUL, FN_MULU, FN_MULSU,
					FN_DIV, FN_DIVU, FN_DIVSU,
					FN_MOD, FN_MODU, FN_MODSU:
						isMc = 1'b1;
					default:
						isMc = 1'b0;
				endcase
			end
			// Immediate forms of multiply
			OP_MULI, OP_MULUI:
				isMc = 1'b1;
			// Immediate forms of divide
			OP_DIVI, OP_DIVUI:
				isMc = 1'b1;
			default:
				isMc = 1'b0;
		endcase
		return isMc;
	endfunction

	assign multicycle = fnIsMulticycle(instr);

endmodule

`default_nettype wire

//--- verilog/decodeRegFields.sv
// Extracts register specifiers and read and write flags from an instruction word
`timescale 1ns/1ps
`default_nettype none

module decodeRegFields (
	input  decode_pkg::instruction_t instr,
	output decode_pkg::regFields_t   fields
);

	import decode_pkg::*;

	logic readsRs1;
	logic readsRs2;
	logic wantsRd;

	// Which operands each format touches
	always_comb
	begin
		readsRs1 = 1'b0;
		readsRs2 = 1'b0;
		wantsRd  = 1'b0;
		case (instr.any.opcode)
			// Register-register reads both sources
			OP_R2:
			begin
				readsRs1 = 1'b1;
				readsRs2 = 1'b1;
				wantsRd  = 1'b1;
			end
			// Immediate and load forms read rs1 only
			OP_ADDI, OP_ANDI, OP_ORI,
			OP_MULI, OP_MULUI, OP_DIVI, OP_DIVUI,
			OP_LOAD:
			begin
				readsRs1 = 1'b1;
				wantsRd  = 1'b1;
			end
			// Store data and branch compare need a second source and no result
			OP_STORE, OP_BRANCH:
			begin
				readsRs1 = 1'b1;
				readsRs2 = 1'b1;
			end
			// NOP and unknown opcodes touch nothing
			default:
			begin
				readsRs1 = 1'b0;
			end
		endcase
	end

	// rd and rs1 sit in the same place in both views
	// rs2 is always taken from the r2 position
	assign fields.rd       = wantsRd ? instr.r2.rd : 5'd0;
	assign fields.rs1      = readsRs1 ? instr.r2.rs1 : 5'd0;
	assign fields.rs2      = readsRs2 ? instr.r2.rs2 : 5'd0;
	assign fields.readsRs1 = readsRs1;
	assign fields.readsRs2 = readsRs2;
	// Register 0 is hardwired so a write to it is dropped here
	assign fields.writesRd = wantsRd && (instr.r2.rd != 5'd0);

endmodule

`default_nettype wire

//--- verilog/decodeStage.sv
// Top level of the decode stage, joins the combinational decoders to the control block
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input  logic                      clk,
	input  logic                      rstN,
	input  decode_pkg::instruction_t  instr,
	input  logic                      instrValid,
	output decode_pkg::decodeBundle_t decoded,
	output logic                      decodedValid,
	output logic                      stall
);

	import decode_pkg::*;

	logic        isMulticycle;
	regFields_t  regFields;
	logic [31:0] immValue;

	// ==================================================
	// Zero-latency datapath decoders
	// ==================================================

	decodeMulticycle uMulticycle (
		.instr      (instr),
		.multicycle (isMulticycle)
	);

	decodeRegFields uRegFields (
		.instr  (instr),
		.fields (regFields)
	);

	decodeImmediate uImmediate (
		.instr (instr),
		.imm   (immValue)
	);

	// ==================================================
	// Registers, acceptance and stall
	// ==================================================

	decodeControl uControl (
		.clk          (clk),
		.rstN         (rstN),
		.instr        (instr),
		.instrValid   (instrValid),
		.multicycle   (isMulticycle),
		.fields       (regFields),
		.imm          (immValue),
		.decoded      (decoded),
		.decodedValid (decodedValid),
		.stall        (stall)
	);

endmodule

`default_nettype wire

//--- verilog/decode_cfg.svh
// Tunable stall lengths and immediate width, included by the decode control block and its checks
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// ==================================================
// Multicycle stall lengths
// ==================================================

// Cycles the stage holds stall high after accepting a multiply
// Covers MUL, MULU, MULSU, MULI and MULUI
`define QD_MUL_STALL 3

// Cycles the stage holds stall high after accepting a divide or modulo
// The divider is iterative so this is the longer of the two
`define QD_DIV_STALL 8

// ==================================================
// Instruction format
// ==================================================

// Width of the immediate field in the register-immediate view
`define QD_IMM_BITS 15

`endif

//--- verilog/decode_pkg.sv
// Shared types for the decode stage: instruction views, opcode and function codes, unit classes
`default_nettype none

package decode_pkg;

	// ==================================================
	// Encodings
	// ==================================================

	// Major opcode in the low seven bits of every instruction word
	typedef enum logic [6:0] {
		OP_R2     = 7'h02,
		OP_ADDI   = 7'h04,
		OP_ANDI   = 7'h08,
		OP_ORI    = 7'h09,
		OP_MULI   = 7'h0C,
		OP_MULUI  = 7'h0D,
		OP_DIVI   = 7'h10,
		OP_DIVUI  = 7'h11,
		OP_LOAD   = 7'h20,
		OP_STORE  = 7'h24,
		OP_BRANCH = 7'h28,
		OP_NOP    = 7'h7F
	} opcode_e;

	// Function code of a register-register operation
	// Multiply, divide and modulo codes sit in their own groups
	typedef enum logic [5:0] {
		FN_ADD   = 6'h04,
		FN_SUB   = 6'h05,
		FN_AND   = 6'h08,
		FN_OR    = 6'h09,
		FN_MUL   = 6'h10,
		FN_MULU  = 6'h11,
		FN_MULSU = 6'h12,
		FN_DIV   = 6'h18,
		FN_DIVU  = 6'h19,
		FN_DIVSU = 6'h1A,
		FN_MOD   = 6'h1C,
		FN_MODU  = 6'h1D,
		FN_MODSU = 6'h1E
	} func_e;

	// Functional unit that will execute the instruction
	typedef enum logic [2:0] {
		UNIT_ALU    = 3'd0,
		UNIT_MUL    = 3'd1,
		UNIT_DIV    = 3'd2,
		UNIT_MEM    = 3'd3,
		UNIT_BRANCH = 3'd4,
		UNIT_NOP    = 3'd5
	} unitClass_e;

	// ==================================================
	// Instruction word views
	// ==================================================

	// Opcode only, used to pick which of the other views applies
	typedef struct packed {
		logic [24:0] rest;
		opcode_e     opcode;
	} anyView_t;

	// Register-register format
	typedef struct packed {
		logic [3:0] spare;
		func_e      func;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [4:0] rd;
		opcode_e    opcode;
	} r2View_t;

	// Register-immediate format
	// The low bits of imm overlap rs2 of the r2 view
	typedef struct packed {
		logic [14:0] imm;
		logic [4:0]  rs1;
		logic [4:0]  rd;
		opcode_e     opcode;
	} riView_t;

	typedef union packed {
		anyView_t any;
		r2View_t  r2;
		riView_t  ri;
	} instruction_t;

	// ==================================================
	// Decoded results
	// ==================================================

	// Register specifiers with their use flags, unused specifiers read as zero
	typedef struct packed {
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic       readsRs1;
		logic       readsRs2;
		logic       writesRd;
	} regFields_t;

	// Everything the execute side needs from one instruction
	typedef struct packed {
		regFields_t  fields;
		logic [31:0] imm;
		unitClass_e  unit;
		logic        multicycle;
		opcode_e     opcode;
	} decodeBundle_t;

endpackage

`default_nettype wire
